//--- rtcAccessSequencer.sv
`timescale 1ns/10ps

module rtcAccessSequencer (
	input  logic clk,
	input  logic reset,
	input  logic cmdValid,
	input  rtcPkg::accessOp cmdOp,
	input  rtcPkg::busData cmdAddr,
	input  rtcPkg::busData cmdData,
	output logic seqReady,
	output logic cycStart,
	output rtcPkg::cycleKind cycKind,
	output rtcPkg::busData cycData,
	input  logic cycDone,
	input  rtcPkg::busData cycReadData,
	output logic done,
	output logic readValid,
	output rtcPkg::busData readData
);
	import rtcPkg::*;

	seqState state;
	accessOp opReg;
	busData dataReg;
	logic accept;
	logic addrDone;
	logic dataDone;

	assign seqReady = (state == seqIdle);
	assign accept = cmdValid && seqReady;
	assign addrDone = (state == seqAddress) && cycDone;
	assign dataDone = (state == seqData) && cycDone;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= seqIdle;
			cycStart <= 1'b0;
			done <= 1'b0;
			readValid <= 1'b0;
		end else begin
			cycStart <= 1'b0;
			done <= 1'b0;
			readValid <= 1'b0;
			case (state)
				seqIdle: begin
					if (accept) begin
						state <= seqAddress;
						cycStart <= 1'b1; // address cycle.
					end
				end
				seqAddress: begin
					if (cycDone) begin
						state <= seqData;
						cycStart <= 1'b1; // data cycle.
					end
				end
				seqData: begin
					if (cycDone) begin
						state <= seqDone;
						done <= 1'b1;
						readValid <= (opReg == opRead);
					end
				end
				seqDone: begin
					state <= seqIdle;
				end
				default: begin
					state <= seqIdle;
				end
			endcase
		end
	end

	// command and cycle payload.
	always_ff @(posedge clk) begin
		if (accept) begin
			opReg <= cmdOp;
			dataReg <= cmdData;
			cycKind <= cycAddress;
			cycData <= cmdAddr;
		end
		if (addrDone) begin
			cycKind <= (opReg == opRead) ? cycRead : cycWrite;
			cycData <= dataReg;
		end
		if (dataDone && opReg == opRead) begin
			readData <= cycReadData;
		end
	end

endmodule

//--- rtcBusCycle.sv
`timescale 1ns/10ps

module rtcBusCycle (
	input  logic clk,
	input  logic reset,
	input  logic cycStart,
	input  rtcPkg::cycleKind cycKind,
	input  rtcPkg::busData cycData,
	output logic cycDone,
	output rtcPkg::busData cycReadData,
	output logic csN,
	output logic wrN,
	output logic rdN,
	output logic ale,
	output logic adOe,
	output rtcPkg::busData adOut,
	input  rtcPkg::busData adIn
);
	import rtcPkg::*;

	busState state;
	cycleKind kindReg;
	logic [2:0] phaseCount;
	logic closing;
	logic setupEnd;
	logic strobeEnd;
	logic holdEnd;

	assign setupEnd = (state == busSetup) && (phaseCount == 3'(setupCycles - 1));
	assign strobeEnd = (state == busStrobe) && (phaseCount == 3'(strobeCycles - 1));
	assign holdEnd = (state == busHold) && (phaseCount == 3'(holdCycles - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= busIdle;
			phaseCount <= '0;
			csN <= 1'b1;
			wrN <= 1'b1;
			rdN <= 1'b1;
			ale <= 1'b0;
			adOe <= 1'b0;
			closing <= 1'b0;
			cycDone <= 1'b0;
		end else begin
			cycDone <= closing; // one clock after csN rises.
			closing <= 1'b0;
			case (state)
				busIdle: begin
					if (cycStart) begin
						state <= busSetup;
						phaseCount <= '0;
						csN <= 1'b0;
						ale <= (cycKind == cycAddress);
						adOe <= (cycKind != cycRead);
					end
				end
				busSetup: begin
					if (setupEnd) begin
						state <= busStrobe;
						phaseCount <= '0;
						if (kindReg == cycRead) begin
							rdN <= 1'b0;
						end else begin
							wrN <= 1'b0;
						end
					end else begin
						phaseCount <= phaseCount + 3'd1;
					end
				end
				busStrobe: begin
					if (strobeEnd) begin
						state <= busHold;
						phaseCount <= '0;
						wrN <= 1'b1;
						rdN <= 1'b1;
					end else begin
						phaseCount <= phaseCount + 3'd1;
					end
				end
				busHold: begin
					if (holdEnd) begin
						state <= busIdle;
						phaseCount <= '0;
						csN <= 1'b1;
						ale <= 1'b0;
						adOe <= 1'b0;
						closing <= 1'b1;
					end else begin
						phaseCount <= phaseCount + 3'd1;
					end
				end
				default: begin
					state <= busIdle;
				end
			endcase
		end
	end

	// kind and bus data held for the whole cycle.
	always_ff @(posedge clk) begin
		if (state == busIdle && cycStart) begin
			kindReg <= cycKind;
			adOut <= cycData;
		end
		if (strobeEnd && kindReg == cycRead) begin
			cycReadData <= adIn; // last strobe clock.
		end
	end

endmodule

//--- rtcBusModel.sv
`timescale 1ns/10ps

module rtcBusModel (
	input  logic clk,
	input  logic reset,
	input  logic csN,
	input  logic wrN,
	input  logic rdN,
	input  logic ale,
	input  logic adOe,
	input  rtcPkg::busData adOut,
	output rtcPkg::busData adIn
);
	import rtcPkg::*;

	busData mem [256];
	busData lastAddr = '0;
	int timingErrors = 0;
	int strobeCount = 0;
	int readCount = 0;
	int strobeWidth = 0;
	int csWidth = 0;

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'(i) ^ 8'hc3; // distinct per address.
		end
	end

	assign adIn = rdN ? '0 : mem[lastAddr];

	// ale high means address phase, low means data phase.
	always @(posedge wrN) begin
		if (!reset && !csN) begin
			if (ale) begin
				lastAddr = adOut;
			end else begin
				mem[lastAddr] = adOut;
			end
		end
	end

	always @(posedge rdN) begin
		if (!reset && !csN) begin
			readCount++;
		end
	end

	// widths in clocks, from pre-edge levels.
	always @(posedge clk) begin
		if (reset) begin
			strobeWidth = 0;
			csWidth = 0;
		end else begin
			if (!rdN && adOe) begin
				$display("controller drives the bus during a read at %0t", $time);
				timingErrors++;
			end
			if (!wrN && !adOe) begin
				$display("controller leaves the bus undriven during a write at %0t", $time);
				timingErrors++;
			end
			if (!wrN || !rdN) begin
				strobeWidth++;
			end else if (strobeWidth != 0) begin
				strobeCount++;
				if (strobeWidth != strobeCycles) begin
					$display("strobe lasted %0d cycles instead of %0d", strobeWidth, strobeCycles);
					timingErrors++;
				end
				strobeWidth = 0;
			end
			if (!csN) begin
				csWidth++;
			end else if (csWidth != 0) begin
				if (csWidth != setupCycles + strobeCycles + holdCycles) begin
					$display("chip select lasted %0d cycles", csWidth);
					timingErrors++;
				end
				csWidth = 0;
			end
		end
	end

endmodule

//--- rtcCommandDecode.sv
`timescale 1ns/10ps

module rtcCommandDecode (
	input  logic clk,
	input  logic reset,
	input  logic initStart,
	input  logic writeStart,
	input  logic readStart,
	input  logic formatStart,
	input  rtcPkg::timeField fieldSel,
	input  rtcPkg::busData writeData,
	input  logic setOne,
	input  logic twelveHour,
	input  logic seqReady,
	output logic cmdValid,
	output rtcPkg::accessOp cmdOp,
	output rtcPkg::busData cmdAddr,
	output rtcPkg::busData cmdData,
	output logic busy
);
	import rtcPkg::*;

	logic anyStart;
	logic take;
	busData fieldAddr;
	accessOp nextOp;
	busData nextAddr;
	busData nextData;

	assign anyStart = initStart | writeStart | readStart | formatStart;
	assign take = anyStart && !cmdValid; // dropped while holding.
	assign busy = cmdValid;

	always_comb begin
		case (fieldSel)
			fieldSeconds: fieldAddr = regSeconds;
			fieldMinutes: fieldAddr = regMinutes;
			fieldHour: fieldAddr = regHour;
			fieldDay: fieldAddr = regDay;
			fieldMonth: fieldAddr = regMonth;
			fieldYear: fieldAddr = regYear;
			default: fieldAddr = regSeconds;
		endcase
	end

	// format beats read beats write beats init.
	always_comb begin
		nextOp = opWrite;
		nextAddr = regControl;
		nextData = '0;
		if (formatStart) begin
			nextAddr = regFormat;
			nextData[controlBit] = twelveHour;
		end else if (readStart) begin
			nextOp = opRead;
			nextAddr = fieldAddr;
		end else if (writeStart) begin
			nextAddr = fieldAddr;
			nextData = writeData;
		end else begin
			nextData[controlBit] = setOne; // init.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmdValid <= 1'b0;
		end else if (take) begin
			cmdValid <= 1'b1;
		end else if (cmdValid && seqReady) begin
			cmdValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cmdOp <= nextOp;
			cmdAddr <= nextAddr;
			cmdData <= nextData;
		end
	end

endmodule

//--- rtcController.f
rtcPkg.sv
rtcCommandDecode.sv
rtcAccessSequencer.sv
rtcBusCycle.sv
rtcController.sv
rtcBusModel.sv
rtcControllerTb.sv

//--- rtcController.sv
`timescale 1ns/10ps

module rtcController (
	input  logic clk,
	input  logic reset,
	input  logic initStart,
	input  logic writeStart,
	input  logic readStart,
	input  logic formatStart,
	input  rtcPkg::timeField fieldSel,
	input  rtcPkg::busData writeData,
	input  logic setOne,
	input  logic twelveHour,
	output logic busy,
	output logic done,
	output rtcPkg::busData readData,
	output logic readValid,
	output logic csN,
	output logic wrN,
	output logic rdN,
	output logic ale,
	output rtcPkg::busData adOut,
	output logic adOe,
	input  rtcPkg::busData adIn
);
	import rtcPkg::*;

	logic cmdValid;
	accessOp cmdOp;
	busData cmdAddr;
	busData cmdData;
	logic seqReady;
	logic cycStart;
	cycleKind cycKind;
	busData cycData;
	logic cycDone;
	busData cycReadData;

	rtcCommandDecode decode (
		.clk(clk),
		.reset(reset),
		.initStart(initStart),
		.writeStart(writeStart),
		.readStart(readStart),
		.formatStart(formatStart),
		.fieldSel(fieldSel),
		.writeData(writeData),
		.setOne(setOne),
		.twelveHour(twelveHour),
		.seqReady(seqReady),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdAddr(cmdAddr),
		.cmdData(cmdData),
		.busy(busy)
	);

	rtcAccessSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdAddr(cmdAddr),
		.cmdData(cmdData),
		.seqReady(seqReady),
		.cycStart(cycStart),
		.cycKind(cycKind),
		.cycData(cycData),
		.cycDone(cycDone),
		.cycReadData(cycReadData),
		.done(done),
		.readValid(readValid),
		.readData(readData)
	);

	rtcBusCycle busCycle (
		.clk(clk),
		.reset(reset),
		.cycStart(cycStart),
		.cycKind(cycKind),
		.cycData(cycData),
		.cycDone(cycDone),
		.cycReadData(cycReadData),
		.csN(csN),
		.wrN(wrN),
		.rdN(rdN),
		.ale(ale),
		.adOe(adOe),
		.adOut(adOut),
		.adIn(adIn)
	);

endmodule

//--- rtcControllerTb.sv
`timescale 1ns/10ps

module rtcControllerTb;
	import rtcPkg::*;

	localparam int clockPeriod = 20;
	localparam int commandCycles = 40;
	localparam int maxCommands = 40;
	localparam time watchdogTime = maxCommands * commandCycles * clockPeriod;

	logic clk;
	logic reset;
	logic initStart;
	logic writeStart;
	logic readStart;
	logic formatStart;
	timeField fieldSel;
	busData writeData;
	logic setOne;
	logic twelveHour;
	logic busy;
	logic done;
	busData readData;
	logic readValid;
	logic csN;
	logic wrN;
	logic rdN;
	logic ale;
	busData adOut;
	logic adOe;
	busData adIn;
	int valueErrors = 0;
	int otherErrors = 0;
	int doneCount = 0;

	rtcController dut (
		.clk(clk), .reset(reset), .initStart(initStart), .writeStart(writeStart),
		.readStart(readStart), .formatStart(formatStart), .fieldSel(fieldSel),
		.writeData(writeData), .setOne(setOne), .twelveHour(twelveHour), .busy(busy),
		.done(done), .readData(readData), .readValid(readValid), .csN(csN), .wrN(wrN),
		.rdN(rdN), .ale(ale), .adOut(adOut), .adOe(adOe), .adIn(adIn)
	);

	rtcBusModel chipModel (
		.clk(clk), .reset(reset), .csN(csN), .wrN(wrN), .rdN(rdN), .ale(ale),
		.adOe(adOe), .adOut(adOut), .adIn(adIn)
	);

	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	initial begin
		#(watchdogTime);
		$display("watchdog expired at %0t, the controller stopped responding", $time);
		$display("TEST FAILED");
		$finish;
	end

	task automatic checkData(input string name, input busData got, input busData expected);
		if (got !== expected) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
			valueErrors++;
		end
	endtask

	task automatic checkField(input string name, input timeField got, input timeField expected);
		if (got !== expected) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
			valueErrors++;
		end
	endtask

	function automatic busData fieldAddress(input timeField f);
		case (f)
			fieldSeconds: return 8'h21;
			fieldMinutes: return 8'h22;
			fieldHour: return 8'h23;
			fieldDay: return 8'h24;
			fieldMonth: return 8'h25;
			fieldYear: return 8'h26;
			default: return 8'hff;
		endcase
	endfunction

	// one-cycle strobe pulse.
	task automatic startCommand(input logic doInit, input logic doWrite, input logic doRead,
			input logic doFormat);
		@(negedge clk);
		initStart = doInit;
		writeStart = doWrite;
		readStart = doRead;
		formatStart = doFormat;
		@(negedge clk);
		initStart = 1'b0;
		writeStart = 1'b0;
		readStart = 1'b0;
		formatStart = 1'b0;
	endtask

	task automatic waitDone(output logic sawValid, output busData got);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		sawValid = 1'b0;
		got = '0;
		while (!seen && cycles < commandCycles) begin
			@(negedge clk);
			cycles++;
			if (done) begin
				seen = 1'b1;
				sawValid = readValid;
				got = readData;
			end
		end
		if (seen) begin
			doneCount++;
		end else begin
			$display("no done pulse within %0d cycles at %0t", commandCycles, $time);
			otherErrors++;
		end
	endtask

	task automatic checkResetState();
		checkBit("csN", csN, 1'b1);
		checkBit("wrN", wrN, 1'b1);
		checkBit("rdN", rdN, 1'b1);
		checkBit("ale", ale, 1'b0);
		checkBit("adOe", adOe, 1'b0);
		checkBit("busy", busy, 1'b0);
		checkBit("done", done, 1'b0);
		checkBit("readValid", readValid, 1'b0);
	endtask

	task automatic testInit(input logic one);
		logic sawValid;
		busData got;
		setOne = one;
		startCommand(1'b1, 1'b0, 1'b0, 1'b0);
		waitDone(sawValid, got);
		checkBit("readValid", sawValid, 1'b0);
		checkData("reg 0x02", chipModel.mem[8'h02], one ? 8'h10 : 8'h00);
	endtask

	task automatic testField(input timeField f);
		logic sawValid;
		busData got;
		busData value;
		value = 8'($urandom);
		if (value == chipModel.mem[fieldAddress(f)]) begin
			value = ~value; // force a visible change.
		end
		fieldSel = f;
		writeData = value;
		startCommand(1'b0, 1'b1, 1'b0, 1'b0);
		waitDone(sawValid, got);
		checkData($sformatf("reg 0x%h", fieldAddress(f)), chipModel.mem[fieldAddress(f)], value);
		startCommand(1'b0, 1'b0, 1'b1, 1'b0);
		waitDone(sawValid, got);
		checkBit("readValid", sawValid, 1'b1);
		checkData("readData", got, value);
		checkField("read field", timeField'(3'(chipModel.lastAddr - 8'h21)), f);
	endtask

	task automatic testFormat(input logic twelve);
		logic sawValid;
		busData got;
		twelveHour = twelve;
		startCommand(1'b0, 1'b0, 1'b0, 1'b1);
		waitDone(sawValid, got);
		checkData("reg 0x00", chipModel.mem[8'h00], twelve ? 8'h10 : 8'h00);
	endtask

	// format wins over read, a write during busy is lost, the next one waits.
	task automatic testHolding();
		logic sawValid;
		busData got;
		busData lostData;
		busData keptData;
		busData oldMonth;
		int oldReads;
		lostData = 8'($urandom);
		keptData = 8'($urandom);
		oldMonth = chipModel.mem[8'h25];
		oldReads = chipModel.readCount;
		if (lostData == oldMonth) begin
			lostData = ~lostData; // a taken write must show.
		end
		if (keptData == chipModel.mem[8'h24]) begin
			keptData = ~keptData;
		end
		@(negedge clk);
		twelveHour = 1'b1;
		fieldSel = fieldDay;
		formatStart = 1'b1;
		readStart = 1'b1;
		@(negedge clk);
		formatStart = 1'b0;
		readStart = 1'b0;
		checkBit("busy after format", busy, 1'b1);
		writeStart = 1'b1;
		fieldSel = fieldMonth;
		writeData = lostData;
		@(negedge clk);
		checkBit("busy after accept", busy, 1'b0);
		fieldSel = fieldDay;
		writeData = keptData;
		@(negedge clk);
		writeStart = 1'b0;
		checkBit("busy while queued", busy, 1'b1);
		waitDone(sawValid, got);
		checkBit("readValid", sawValid, 1'b0);
		checkData("reg 0x00", chipModel.mem[8'h00], 8'h10);
		waitDone(sawValid, got);
		checkBit("readValid", sawValid, 1'b0);
		checkData("reg 0x24", chipModel.mem[8'h24], keptData);
		checkData("reg 0x25", chipModel.mem[8'h25], oldMonth);
		if (chipModel.readCount != oldReads) begin
			$display("a read reached the bus although format had priority");
			otherErrors++;
		end
	endtask

	initial begin
		void'($urandom(32'h9bca_cc58));
		reset = 1'b1;
		initStart = 1'b0;
		writeStart = 1'b0;
		readStart = 1'b0;
		formatStart = 1'b0;
		fieldSel = fieldSeconds;
		writeData = '0;
		setOne = 1'b0;
		twelveHour = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checkResetState();
		testInit(1'b1);
		testInit(1'b0);
		for (int i = 0; i < 6; i++) begin
			testField(timeField'(i));
		end
		testFormat(1'b1);
		testFormat(1'b0);
		testHolding();
		repeat (4) @(negedge clk);
		if (chipModel.strobeCount != 2 * doneCount) begin
			$display("saw %0d strobes for %0d commands", chipModel.strobeCount, doneCount);
			otherErrors++;
		end
		$display("errors: %0d value, %0d timing, %0d other", valueErrors,
			chipModel.timingErrors, otherErrors);
		if (valueErrors + chipModel.timingErrors + otherErrors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- rtcPkg.sv
package rtcPkg;

	localparam int dataWidth = 8;

	typedef logic [dataWidth-1:0] busData;

	// field chosen for a read or write.
	typedef enum logic [2:0] {
		fieldSeconds,
		fieldMinutes,
		fieldHour,
		fieldDay,
		fieldMonth,
		fieldYear
	} timeField;

	localparam busData regFormat = 8'h00; // 12/24 hour select.
	localparam busData regControl = 8'h02;
	localparam busData regSeconds = 8'h21;
	localparam busData regMinutes = 8'h22;
	localparam busData regHour = 8'h23;
	localparam busData regDay = 8'h24;
	localparam busData regMonth = 8'h25;
	localparam busData regYear = 8'h26;

	localparam int controlBit = 4; // init and format bit.

	typedef enum logic {
		opWrite,
		opRead
	} accessOp;

	typedef enum logic [1:0] {
		cycAddress,
		cycWrite,
		cycRead
	} cycleKind;

	// bus timing in clocks.
	localparam int setupCycles = 2;
	localparam int strobeCycles = 4;
	localparam int holdCycles = 2;

	typedef enum logic [1:0] {
		seqIdle,
		seqAddress,
		seqData,
		seqDone
	} seqState;

	typedef enum logic [1:0] {
		busIdle,
		busSetup,
		busStrobe,
		busHold
	} busState;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the RTC controller simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
	-f rtcController.f \
	--top-module rtcControllerTb \
	-o rtcSim

output=$(./obj_dir/rtcSim)
echo "$output"

if echo "$output" | grep -q "^TEST PASSED$"; then
	exit 0
fi
exit 1
